// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath sizes
  localparam int word_w     = 16; // data and instruction word
  localparam int addr_w     = 6;  // program and data address
  localparam int prog_depth = 64; // program words
  localparam int data_depth = 64; // data ram words
  localparam int reg_count  = 32;
  localparam int reg_idx_w  = 5;  // low bits of the register byte

  // uart bit timing in clock cycles
  localparam int clk_per_bit = 8;
  localparam int cyc_cnt_w   = $clog2(clk_per_bit);

  // opcode byte values from the upper byte of the first instruction word
  typedef enum logic [7:0] {
    op_halt        = 8'h00,
    op_jmp         = 8'h01,
    op_ram2reg     = 8'h02,
    op_reg2ram     = 8'h03,
    op_num2reg     = 8'h04,
    op_regminusnum = 8'h06,
    op_out         = 8'h0F  // sends low byte of rd on the uart
  } opcode_e;

  // one decoded two-word instruction
  typedef struct packed {
    opcode_e               op;
    logic                  illegal; // opcode byte not in opcode_e
    logic [reg_idx_w-1:0]  rd;
    logic [word_w-1:0]     operand; // second word
  } decoded_instr_t;

  // program memory write port
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] data;
  } prog_load_t;

  // execute stage answer to the decoder
  typedef struct packed {
    logic              done;   // one cycle pulse
    logic              jump;   // take target instead of pc+2
    logic [addr_w-1:0] target;
    logic              stop;   // halt or illegal
  } exec_result_t;

endpackage

`default_nettype wire

// File: hdl/instr_decode.sv
`default_nettype none

// program memory, pc and two word fetch
// next fetch only after result.done
module instr_decode import cpu_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  prog_load_t     load,
  input  logic           run,
  input  exec_result_t   result,
  output decoded_instr_t instr,   // held stable until done
  output logic           issue,   // one cycle pulse
  output logic           halted,
  output logic           illegal
);

  typedef enum logic [1:0] {
    idle,
    fetch_hi,  // read opcode/register word
    fetch_lo,  // read operand word and issue
    wait_exec
  } fetch_state_e;

  fetch_state_e      state;
  logic [addr_w-1:0] pc;
  logic [word_w-1:0] hi_word; // first word of current instruction
  logic [word_w-1:0] prog_mem [prog_depth];

  // split first word and flag unknown opcode bytes
  function automatic decoded_instr_t decode(input logic [word_w-1:0] hi,
                                            input logic [word_w-1:0] lo);
    decoded_instr_t d;
    logic [7:0]     op_byte;
    op_byte   = hi[word_w-1 -: 8];
    d.rd      = hi[reg_idx_w-1:0];  // low bits of register byte
    d.operand = lo;
    d.illegal = 1'b0;
    case (op_byte)
      op_halt, op_jmp, op_ram2reg, op_reg2ram,
      op_num2reg, op_regminusnum, op_out: d.op = opcode_e'(op_byte);
      default: begin
        d.op      = op_halt; // treated as a stop by execute
        d.illegal = 1'b1;
      end
    endcase
    return d;
  endfunction

  // program write port
  always_ff @(posedge clk) begin
    if (load.en) prog_mem[load.addr] <= load.data;
  end

  // instruction word registers
  always_ff @(posedge clk) begin
    if (state == fetch_hi) hi_word <= prog_mem[pc];
    if (state == fetch_lo) instr <= decode(hi_word, prog_mem[pc + addr_w'(1)]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      pc      <= '0;
      issue   <= 1'b0;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      issue <= 1'b0; // pulse
      case (state)
        idle: begin
          if (run) begin
            pc      <= '0;
            halted  <= 1'b0;
            illegal <= 1'b0;
            state   <= fetch_hi;
          end
        end
        fetch_hi: state <= fetch_lo;
        fetch_lo: begin
          issue <= 1'b1; // instr valid next cycle with it
          state <= wait_exec;
        end
        wait_exec: begin
          if (result.done) begin
            if (result.stop) begin
              state   <= idle;
              halted  <= 1'b1;
              illegal <= instr.illegal;
            end else begin
              pc    <= result.jump ? result.target : pc + addr_w'(2);
              state <= fetch_hi;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`default_nettype none

// register file, data ram and one op per issue
// out waits on tx_busy before firing tx_start
module exec_unit import cpu_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  decoded_instr_t instr,
  input  logic           issue,
  input  logic           tx_busy,
  output exec_result_t   result,
  output logic           tx_start, // pulse with tx_byte valid
  output logic [7:0]     tx_byte
);

  typedef enum logic {
    ex_ready,
    ex_out_wait // out issued while serializer busy
  } exec_state_e;

  exec_state_e       state;
  logic [word_w-1:0] regs     [reg_count];
  logic [word_w-1:0] data_ram [data_depth];
  logic [addr_w-1:0] ram_addr;
  logic [word_w-1:0] rd_val;

  assign ram_addr = instr.operand[addr_w-1:0]; // low bits only
  assign rd_val   = regs[instr.rd];

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ex_ready;
      result   <= '0;
      tx_start <= 1'b0;
      tx_byte  <= '0;
      for (int i = 0; i < reg_count; i++) regs[i] <= '0;
      for (int j = 0; j < data_depth; j++) data_ram[j] <= '0;
    end else begin
      result.done <= 1'b0; // pulses
      tx_start    <= 1'b0;
      case (state)
        ex_ready: begin
          if (issue) begin
            result.jump   <= 1'b0;
            result.stop   <= 1'b0;
            result.target <= ram_addr; // only used with jump
            if (instr.illegal) begin
              result.stop <= 1'b1;
              result.done <= 1'b1;
            end else begin
              case (instr.op)
                op_num2reg: begin
                  regs[instr.rd] <= instr.operand;
                  result.done    <= 1'b1;
                end
                op_ram2reg: begin
                  regs[instr.rd] <= data_ram[ram_addr];
                  result.done    <= 1'b1;
                end
                op_reg2ram: begin
                  data_ram[ram_addr] <= rd_val;
                  result.done        <= 1'b1;
                end
                op_regminusnum: begin
                  regs[instr.rd] <= rd_val - instr.operand; // wraps mod 2^16
                  result.done    <= 1'b1;
                end
                op_jmp: begin
                  result.jump <= 1'b1;
                  result.done <= 1'b1;
                end
                op_out: begin
                  if (tx_busy) begin
                    state <= ex_out_wait; // stall while decoder holds instr
                  end else begin
                    tx_start    <= 1'b1;
                    tx_byte     <= rd_val[7:0];
                    result.done <= 1'b1;
                  end
                end
                default: begin // op_halt
                  result.stop <= 1'b1;
                  result.done <= 1'b1;
                end
              endcase
            end
          end
        end
        ex_out_wait: begin
          if (!tx_busy) begin
            tx_start    <= 1'b1;
            tx_byte     <= rd_val[7:0];
            result.done <= 1'b1;
            state       <= ex_ready;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_result.sv
`default_nettype none

// 8n1 serializer sending lsb first
module uart_result import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start, // accepted only when idle
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  typedef enum logic [1:0] {
    idle,
    start_bit,
    data_bits,
    stop_bit
  } uart_state_e;

  uart_state_e          state;
  logic [2:0]           bit_cnt; // data bit index
  logic [cyc_cnt_w-1:0] cyc_cnt; // cycles within one bit
  logic [7:0]           shreg;   // frame payload
  logic                 bit_end;

  assign bit_end = cyc_cnt == cyc_cnt_w'(clk_per_bit - 1);
  assign tx_busy = state != idle; // high from cycle after tx_start

  // line level from state
  always_comb begin
    case (state)
      start_bit: tx = 1'b0;
      data_bits: tx = shreg[bit_cnt];
      default:   tx = 1'b1; // idle and stop bit
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == idle && tx_start) shreg <= tx_byte;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      bit_cnt <= '0;
      cyc_cnt <= '0;
    end else begin
      if (state == idle) begin
        cyc_cnt <= '0;
        bit_cnt <= '0;
        if (tx_start) state <= start_bit;
      end else begin
        cyc_cnt <= bit_end ? '0 : cyc_cnt + cyc_cnt_w'(1);
        if (bit_end) begin
          case (state)
            start_bit: state <= data_bits;
            data_bits: begin
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7) state <= stop_bit; // last data bit
            end
            default:   state <= idle; // stop bit done
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

// small 16 bit register machine
// fetch/decode -> execute -> uart serializer
module cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  prog_load_t load,   // program writes only while idle
  input  logic       run,    // one cycle start pulse
  output logic       tx,     // 8n1 serial out
  output logic       halted,
  output logic       illegal
);

  decoded_instr_t instr;    // decode -> execute
  logic           issue;
  exec_result_t   result;   // execute -> decode
  logic           tx_start; // execute -> uart
  logic [7:0]     tx_byte;
  logic           tx_busy;  // uart back-pressure

  instr_decode instr_decode_i (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .run     (run),
    .result  (result),
    .instr   (instr),
    .issue   (issue),
    .halted  (halted),
    .illegal (illegal)
  );

  exec_unit exec_unit_i (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .issue    (issue),
    .tx_busy  (tx_busy),
    .result   (result),
    .tx_start (tx_start),
    .tx_byte  (tx_byte)
  );

  uart_result uart_result_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// File: test/cpu_tb_props.sv
`default_nettype none

// control strobe checks bound into exec_unit
module cpu_tb_props import cpu_pkg::*; (
  input logic         clk,
  input logic         rst,
  input logic         issue,
  input logic         tx_busy,
  input logic         tx_start,
  input exec_result_t result
);

  logic in_flight; // issued and done not seen yet

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
    end else if (issue) begin
      in_flight <= 1'b1;
    end else if (result.done) begin
      in_flight <= 1'b0;
    end
  end

  start_when_idle: assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
    else $error("tx_start fired while tx_busy was high");

  done_after_issue: assert property (@(posedge clk) disable iff (rst) result.done |-> in_flight)
    else $error("done without an earlier issue");

  one_in_flight: assert property (@(posedge clk) disable iff (rst) issue |-> !in_flight)
    else $error("issue repeated before done");

endmodule

`default_nettype wire

// File: test/cpu_tb.sv
`default_nettype none

// testbench for cpu_top
// cases come from program_input.hex
// uart bytes decoded by a local receiver
module cpu_tb import cpu_pkg::*; ();

  localparam int timeout_cyc = 20000;            // limit for each wait loop
  localparam int stim_words  = 256;
  localparam int quiet_cyc   = 12 * clk_per_bit; // longer than one frame

  logic       clk;
  logic       rst;
  prog_load_t load;
  logic       run;
  logic       tx;
  logic       halted;
  logic       illegal;

  logic [word_w-1:0] stim_mem [stim_words];
  int                ptr;      // read position in stim_mem
  int                case_cnt;

  cpu_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .run     (run),
    .tx      (tx),
    .halted  (halted),
    .illegal (illegal)
  );

  // strobe checks inside the execute stage
  bind exec_unit cpu_tb_props props_i (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .result   (result)
  );

  always #2 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      report_failure($sformatf("ERR t=%0t %s exp=%02h act=%02h", $time, name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("ERR t=%0t %s exp=%b act=%b", $time, name, exp, act));
  endtask

  // returns at the first negedge with tx low
  task automatic wait_start_bit();
    int n;
    n = 0;
    while (tx !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > timeout_cyc) report_failure("timeout waiting for a start bit on tx");
    end
  endtask

  // samples mid-bit from there on
  task automatic receive_byte(output logic [7:0] val);
    repeat (clk_per_bit / 2 - 1) @(negedge clk);
    if (tx !== 1'b0) report_failure("start bit on tx ended too early");
    for (int i = 0; i < 8; i++) begin
      repeat (clk_per_bit) @(negedge clk);
      val[i] = tx; // lsb first
    end
    repeat (clk_per_bit) @(negedge clk);
    if (tx !== 1'b1) report_failure("stop bit on tx was low");
  endtask

  // no frame may start before halt or shortly after it
  task automatic wait_halt_and_quiet();
    int n;
    n = 0;
    while (halted !== 1'b1) begin
      @(negedge clk);
      if (tx !== 1'b1) report_failure("unexpected start bit on tx before halt");
      n++;
      if (n > timeout_cyc) report_failure("timeout waiting for halted");
    end
    repeat (quiet_cyc) begin
      @(negedge clk);
      if (tx !== 1'b1) report_failure("unexpected start bit on tx after halt");
    end
  endtask

  // entered and left 1 unit after a rising edge
  task automatic load_program(input int base, input int count);
    for (int i = 0; i < count; i++) begin
      load.en   = 1'b1;
      load.addr = addr_w'(i);
      load.data = stim_mem[base + i];
      @(posedge clk);
      #1;
    end
    load.en = 1'b0;
  endtask

  task automatic pulse_run();
    run = 1'b1;
    @(posedge clk);
    #1;
    run = 1'b0;
  endtask

  task automatic check_idle_after_reset();
    repeat (20) begin
      @(negedge clk);
      check_flag("tx", 1'b1, tx);
      check_flag("halted", 1'b0, halted);
      check_flag("illegal", 1'b0, illegal);
    end
    @(posedge clk);
    #1;
  endtask

  // word count, words, byte count, bytes, illegal flag
  task automatic run_case();
    int         word_cnt;
    int         byte_cnt;
    int         base;
    logic [7:0] got;
    word_cnt = int'(stim_mem[ptr]);
    base     = ptr + 1;
    ptr      = base + word_cnt;
    byte_cnt = int'(stim_mem[ptr]);
    load_program(base, word_cnt);
    pulse_run();
    for (int b = 0; b < byte_cnt; b++) begin
      wait_start_bit();
      receive_byte(got);
      check_byte("tx", stim_mem[ptr + 1 + b][7:0], got);
    end
    ptr = ptr + 1 + byte_cnt;
    wait_halt_and_quiet();
    check_flag("halted", 1'b1, halted);
    check_flag("illegal", stim_mem[ptr][0], illegal);
    ptr = ptr + 1;
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    run      = 1'b0;
    load     = '0;
    ptr      = 0;
    case_cnt = 0;
    $readmemh("test/program_input.hex", stim_mem);
    repeat (2) @(posedge clk); // two reset cycles
    #1;
    rst = 1'b0;
    check_idle_after_reset();
    // word count of zero ends the list
    while (ptr < stim_words && stim_mem[ptr] !== '0 && !$isunknown(stim_mem[ptr])) begin
      run_case();
      case_cnt++;
    end
    if (case_cnt > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      report_failure("no test cases were read from program_input.hex");
    end
  end

endmodule

`default_nettype wire

// File: test/program_input.hex
// per case: word count, program words, uart byte count, bytes, illegal flag
// instruction is {opcode, reg} then operand, a word count of 0000 ends the list
// num2reg r1 1234, out r1, halt
0006
0401 1234 0F01 0000 0000 0000
0001 0034
0000
// reg2ram r2 to ram 5, ram2reg into r3, out r3, halt
000A
0402 BEEF 0302 0005 0203 0005 0F03 0000 0000 0000
0001 00EF
0000
// r4 = 3 - 5 wraps to fffe, out r4 and out r6 back to back
000C
0404 0003 0406 1357 0604 0005 0F04 0000 0F06 0000 0000 0000
0002 00FE 0057
0000
// jmp to 8 skips out r8 at 6
000C
0407 0041 0408 0042 0100 0008 0F08 0000 0F07 0000 0000 0000
0001 0041
0000
// opcode 05 stops with illegal, the out after it never runs
0008
0409 0055 0F09 0000 0500 0000 0F09 0000
0001 0055
0001
// end of list
0000

// File: files.f
hdl/cpu_pkg.sv
hdl/instr_decode.sv
hdl/exec_unit.sv
hdl/uart_result.sv
hdl/cpu_top.sv
test/cpu_tb_props.sv
test/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module cpu_tb -o cpu_sim || exit 1
sim_out=$(./obj_dir/cpu_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
